// File: common/gb_map_pkg.sv
package gb_map_pkg;

	// bus widths
	localparam int addr_w = 16;
	localparam int data_w = 8;

	// --------------------
	// single byte registers
	localparam logic [addr_w-1:0] joy_addr  = 16'hff00; // P1 joypad
	localparam logic [addr_w-1:0] div_addr  = 16'hff04;
	localparam logic [addr_w-1:0] tima_addr = 16'hff05;
	localparam logic [addr_w-1:0] tma_addr  = 16'hff06;
	localparam logic [addr_w-1:0] tac_addr  = 16'hff07;
	localparam logic [addr_w-1:0] if_addr   = 16'hff0f; // interrupt flags
	localparam logic [addr_w-1:0] svbk_addr = 16'hff70; // wram bank select
	localparam logic [addr_w-1:0] ie_addr   = 16'hffff; // interrupt enable

	// --------------------
	// memory regions
	localparam logic [addr_w-1:0] wram_base = 16'hc000; // 8k window, c000-dfff
	localparam logic [addr_w-1:0] zp_base   = 16'hff80; // 127 bytes up to fffe

	localparam int bank_w       = 3;  // svbk field
	localparam int bank_bytes_w = 12; // 4k per bank
	localparam int zp_w         = 7;

	// what an address hits
	typedef enum logic [2:0] {
		none, joy, timer, irq_if, irq_ie, svbk, wram, zpram
	} io_sel_t;

endpackage

// File: common/gb_bus_pkg.sv
package gb_bus_pkg;

	// axi response codes, slave answers okay only
	typedef enum logic [1:0] {
		okay   = 2'b00,
		exokay = 2'b01,
		slverr = 2'b10,
		decerr = 2'b11
	} axi_resp_t;

	// one transaction at a time
	typedef enum logic [1:0] {
		idle, write_resp, read_wait, read_resp
	} bus_state_t;

	// --------------------
	// interrupt sources, highest priority first
	typedef enum logic [2:0] {
		vblank, lcdc, timer, serial, joypad
	} irq_src_t;

	localparam int irq_n = 5;
	localparam logic [7:0] irq_vec_base = 8'h40; // vblank, +8 per source
	localparam logic [7:0] irq_idle_vec = 8'h55; // nothing pending

endpackage

// File: design/bus_fsm.sv
`timescale 1ns/1ps

module bus_fsm (
	input  logic                          clk_cpu,
	input  logic                          reset,
	input  logic [gb_map_pkg::addr_w-1:0] awaddr,
	input  logic                          awvalid,
	output logic                          awready,
	input  logic [gb_map_pkg::data_w-1:0] wdata,
	input  logic [gb_map_pkg::data_w/8-1:0] wstrb,
	input  logic                          wvalid,
	output logic                          wready,
	output logic [1:0]                    bresp,
	output logic                          bvalid,
	input  logic                          bready,
	input  logic [gb_map_pkg::addr_w-1:0] araddr,
	input  logic                          arvalid,
	output logic                          arready,
	output logic [gb_map_pkg::data_w-1:0] rdata,
	output logic [1:0]                    rresp,
	output logic                          rvalid,
	input  logic                          rready,
	output logic [gb_map_pkg::addr_w-1:0] acc_addr,
	output logic [gb_map_pkg::data_w-1:0] acc_wdata,
	output logic                          acc_wr,
	output logic                          acc_rd,
	input  logic [gb_map_pkg::data_w-1:0] rd_data
);
	import gb_bus_pkg::*;

	bus_state_t state;
	logic       aw_rdy; // shared by aw and w
	logic       ar_rdy;
	logic       wr_go;
	logic       rd_go;

	assign awready = aw_rdy;
	assign wready  = aw_rdy;
	assign arready = ar_rdy & ~awvalid & ~wvalid; // pending write wins
	assign bresp   = okay;
	assign rresp   = okay;

	assign wr_go = aw_rdy & awvalid & wvalid;
	assign rd_go = arready & arvalid;

	// --------------------
	// control fsm
	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			state  <= idle;
			aw_rdy <= 1'b0;
			ar_rdy <= 1'b0;
			bvalid <= 1'b0;
			rvalid <= 1'b0;
			acc_wr <= 1'b0;
			acc_rd <= 1'b0;
		end else begin
			acc_wr <= 1'b0; // strobes last one cycle
			acc_rd <= 1'b0;
			case (state)
				idle: begin
					if (wr_go) begin
						acc_wr <= wstrb[0]; // no strobe, no effect
						aw_rdy <= 1'b0;
						ar_rdy <= 1'b0;
						state  <= write_resp;
					end else if (rd_go) begin
						acc_rd <= 1'b1;
						aw_rdy <= 1'b0;
						ar_rdy <= 1'b0;
						state  <= read_wait;
					end else begin
						aw_rdy <= awvalid & wvalid;
						ar_rdy <= 1'b1;
					end
				end
				write_resp: begin
					if (!bvalid)
						bvalid <= 1'b1; // same edge as register update
					else if (bready) begin
						bvalid <= 1'b0;
						state  <= idle;
					end
				end
				read_wait: begin
					if (!acc_rd) begin // ram data settled
						rvalid <= 1'b1;
						state  <= read_resp;
					end
				end
				read_resp: begin
					if (rready) begin
						rvalid <= 1'b0;
						state  <= idle;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	// address, write data and read data hold
	always_ff @(posedge clk_cpu) begin
		if (wr_go) begin
			acc_addr  <= awaddr;
			acc_wdata <= wdata;
		end else if (rd_go)
			acc_addr <= araddr;
		if (state == read_wait && !acc_rd)
			rdata <= rd_data;
	end

endmodule

// File: design/io_decode.sv
`timescale 1ns/1ps

module io_decode (
	input  logic                          clk_cpu,
	input  logic                          reset,
	input  logic [gb_map_pkg::addr_w-1:0] acc_addr,
	input  logic                          acc_wr,
	input  logic                          acc_rd,
	output logic                          joy_we,
	output logic                          timer_we,
	output logic                          if_we,
	output logic                          ie_we,
	output logic                          svbk_we,
	output logic                          wram_we,
	output logic                          zp_we,
	input  logic [gb_map_pkg::data_w-1:0] joy_do,
	input  logic [gb_map_pkg::data_w-1:0] timer_do,
	input  logic [gb_map_pkg::data_w-1:0] if_do,
	input  logic [gb_map_pkg::data_w-1:0] ie_do,
	input  logic [gb_map_pkg::data_w-1:0] svbk_do,
	input  logic [gb_map_pkg::data_w-1:0] wram_do,
	input  logic [gb_map_pkg::data_w-1:0] zp_do,
	output logic [gb_map_pkg::data_w-1:0] rd_data
);
	import gb_map_pkg::*;

	io_sel_t           sel;
	io_sel_t           sel_q;   // select of the read in flight
	logic [data_w-1:0] reg_mux;
	logic [data_w-1:0] reg_q;   // small registers sampled with the ram

	// --------------------
	// address map
	always_comb begin
		sel = none;
		if (acc_addr == joy_addr)
			sel = joy;
		else if (acc_addr[addr_w-1:2] == div_addr[addr_w-1:2])
			sel = timer; // ff04-ff07
		else if (acc_addr == if_addr)
			sel = irq_if;
		else if (acc_addr == ie_addr)
			sel = irq_ie; // before zpram, ffff is not zero page
		else if (acc_addr == svbk_addr)
			sel = svbk;
		else if (acc_addr[addr_w-1:13] == wram_base[addr_w-1:13])
			sel = wram;
		else if (acc_addr[addr_w-1:zp_w] == zp_base[addr_w-1:zp_w])
			sel = zpram;
	end

	assign joy_we   = acc_wr && sel == joy;
	assign timer_we = acc_wr && sel == timer;
	assign if_we    = acc_wr && sel == irq_if;
	assign ie_we    = acc_wr && sel == irq_ie;
	assign svbk_we  = acc_wr && sel == svbk;
	assign wram_we  = acc_wr && sel == wram;
	assign zp_we    = acc_wr && sel == zpram;

	always_comb begin
		case (sel)
			joy:     reg_mux = joy_do;
			timer:   reg_mux = timer_do;
			irq_if:  reg_mux = if_do;
			irq_ie:  reg_mux = ie_do;
			svbk:    reg_mux = svbk_do;
			default: reg_mux = 8'hff; // unmapped
		endcase
	end

	always_ff @(posedge clk_cpu) begin
		if (reset)
			sel_q <= none;
		else if (acc_rd)
			sel_q <= sel;
	end

	always_ff @(posedge clk_cpu) begin
		if (acc_rd)
			reg_q <= reg_mux;
	end

	// ram outputs are already registered
	assign rd_data = (sel_q == wram)  ? wram_do :
	                 (sel_q == zpram) ? zp_do   : reg_q;

endmodule

// File: timer/gb_timer.sv
`timescale 1ns/1ps

module gb_timer (
	input  logic                          clk_cpu,
	input  logic                          reset,
	input  logic                          we,
	input  logic [1:0]                    addr,   // ff04-ff07 low bits
	input  logic [gb_map_pkg::data_w-1:0] wdata,
	output logic [gb_map_pkg::data_w-1:0] rdata,
	output logic                          timer_irq
);
	import gb_map_pkg::*;

	logic [15:0]       div_cnt; // DIV is the upper byte
	logic [data_w-1:0] tima;
	logic [data_w-1:0] tma;
	logic [2:0]        tac;     // enable + clock select
	logic              tap;
	logic              tap_en;
	logic              tap_q;
	logic              tick;
	logic              wr_div, wr_tima, wr_tma, wr_tac;

	assign wr_div  = we && addr == div_addr[1:0];
	assign wr_tima = we && addr == tima_addr[1:0];
	assign wr_tma  = we && addr == tma_addr[1:0];
	assign wr_tac  = we && addr == tac_addr[1:0];

	// --------------------
	// tima clock source
	always_comb begin
		case (tac[1:0])
			2'd0: tap = div_cnt[9]; // slowest
			2'd1: tap = div_cnt[3];
			2'd2: tap = div_cnt[5];
			2'd3: tap = div_cnt[7];
		endcase
	end

	assign tap_en    = tap & tac[2];
	assign tick      = tap_q & ~tap_en;                        // falling edge
	assign timer_irq = tick && tima == 8'hff && !wr_tima;      // overflow

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			div_cnt <= '0;
			tima    <= '0;
			tma     <= '0;
			tac     <= '0;
			tap_q   <= 1'b0;
		end else begin
			div_cnt <= wr_div ? '0 : div_cnt + 16'd1; // any write clears
			tap_q   <= tap_en;
			if (wr_tima)
				tima <= wdata; // cpu write beats the tick
			else if (tick)
				tima <= (tima == 8'hff) ? tma : tima + 8'd1; // reload on wrap
			if (wr_tma)
				tma <= wdata;
			if (wr_tac)
				tac <= wdata[2:0];
		end
	end

	always_comb begin
		case (addr)
			div_addr[1:0]:  rdata = div_cnt[15:8];
			tima_addr[1:0]: rdata = tima;
			tma_addr[1:0]:  rdata = tma;
			default:        rdata = {5'b11111, tac}; // unused bits read high
		endcase
	end

endmodule

// File: design/irq_ctrl.sv
`timescale 1ns/1ps

module irq_ctrl (
	input  logic                          clk_cpu,
	input  logic                          reset,
	input  logic                          if_we,
	input  logic                          ie_we,
	input  logic [gb_map_pkg::data_w-1:0] wdata,
	input  logic [gb_bus_pkg::irq_n-1:0]  events,  // one cycle pulses
	input  logic                          irq_ack,
	output logic [gb_map_pkg::data_w-1:0] if_do,
	output logic [gb_map_pkg::data_w-1:0] ie_do,
	output logic                          irq,
	output logic [7:0]                    irq_vector
);
	import gb_bus_pkg::*;

	logic [irq_n-1:0] if_r;
	logic [irq_n-1:0] ie_r;
	logic [irq_n-1:0] pending;
	logic [irq_n-1:0] ack_mask; // highest pending source only
	logic [irq_n-1:0] if_next;

	assign pending = if_r & ie_r;
	assign irq     = |pending;

	// --------------------
	// priority encoder, lowest index wins
	always_comb begin
		ack_mask   = '0;
		irq_vector = irq_idle_vec;
		for (int i = irq_n - 1; i >= 0; i--) begin
			if (pending[i]) begin
				ack_mask    = '0;
				ack_mask[i] = 1'b1;
				irq_vector  = irq_vec_base + 8'(i * 8);
			end
		end
	end

	always_comb begin
		if_next = if_we ? wdata[irq_n-1:0] : if_r; // cpu write replaces
		if (irq_ack)
			if_next = if_next & ~ack_mask;
		if_next = if_next | events; // new event beats a clear
	end

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			if_r <= '0;
			ie_r <= '0;
		end else begin
			if_r <= if_next;
			if (ie_we)
				ie_r <= wdata[irq_n-1:0];
		end
	end

	assign if_do = {3'b111, if_r}; // top bits read as 1
	assign ie_do = {3'b000, ie_r};

endmodule

// File: design/joypad.sv
`timescale 1ns/1ps

module joypad (
	input  logic                          clk_cpu,
	input  logic                          reset,
	input  logic                          we,
	input  logic [gb_map_pkg::data_w-1:0] wdata,
	input  logic [7:0]                    joystick, // 1 = pressed
	output logic [gb_map_pkg::data_w-1:0] joy_do,
	output logic                          joy_irq
);
	logic [1:0] p54;      // P15/P14 select, active low
	logic [3:0] dir_n;
	logic [3:0] btn_n;
	logic [7:0] lines_d1;
	logic [7:0] lines_d2;

	// P10-P13 line order of the real pad
	assign dir_n = ~{joystick[2], joystick[3], joystick[1], joystick[0]};
	assign btn_n = ~joystick[7:4];

	assign joy_do = {2'b11, p54, (dir_n | {4{p54[0]}}) & (btn_n | {4{p54[1]}})};

	// any line going low, select ignored
	assign joy_irq = |(lines_d2 & ~lines_d1);

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			p54      <= 2'b00;
			lines_d1 <= 8'hff; // all released
			lines_d2 <= 8'hff;
		end else begin
			if (we)
				p54 <= wdata[5:4];
			lines_d1 <= {btn_n, dir_n};
			lines_d2 <= lines_d1;
		end
	end

endmodule

// File: design/work_ram.sv
`timescale 1ns/1ps

module work_ram #(
	parameter int wram_banks = 8
) (
	input  logic                          clk_cpu,
	input  logic                          reset,
	input  logic                          wram_we,
	input  logic                          zp_we,
	input  logic                          svbk_we,
	input  logic [gb_map_pkg::addr_w-1:0] acc_addr,
	input  logic [gb_map_pkg::data_w-1:0] acc_wdata,
	output logic [gb_map_pkg::data_w-1:0] wram_do,
	output logic [gb_map_pkg::data_w-1:0] zp_do,
	output logic [gb_map_pkg::data_w-1:0] svbk_do
);
	import gb_map_pkg::*;

	localparam int bank_bits = $clog2(wram_banks);
	localparam int wram_aw   = bank_bits + bank_bytes_w;
	localparam logic [bank_w-1:0] bank_mask = bank_w'(wram_banks - 1);

	logic [data_w-1:0]  wram_mem [2**wram_aw];
	logic [data_w-1:0]  zp_mem [2**zp_w - 1];  // ffff is IE and not ram
	logic [bank_w-1:0]  bank_r;
	logic [bank_w-1:0]  bank_wr;
	logic [bank_w-1:0]  bank_sel;
	logic [wram_aw-1:0] wram_a;

	// --------------------
	// svbk register where zero maps to bank 1
	assign bank_wr = acc_wdata[bank_w-1:0] & bank_mask;

	always_ff @(posedge clk_cpu) begin
		if (reset)
			bank_r <= bank_w'(1);
		else if (svbk_we)
			bank_r <= (bank_wr == '0) ? bank_w'(1) : bank_wr;
	end

	assign svbk_do = {{(data_w - bank_w){1'b1}}, bank_r};

	// c000-cfff fixed to bank 0 and d000-dfff switched
	assign bank_sel = acc_addr[bank_bytes_w] ? bank_r : '0;
	assign wram_a   = {bank_sel[bank_bits-1:0], acc_addr[bank_bytes_w-1:0]};

	always_ff @(posedge clk_cpu) begin
		if (wram_we)
			wram_mem[wram_a] <= acc_wdata;
		wram_do <= wram_mem[wram_a]; // sync read returns old data on write
	end

	always_ff @(posedge clk_cpu) begin
		if (zp_we)
			zp_mem[acc_addr[zp_w-1:0]] <= acc_wdata;
		zp_do <= zp_mem[acc_addr[zp_w-1:0]];
	end

endmodule

// File: design/gb_io_top.sv
`timescale 1ns/1ps

module gb_io_top #(
	parameter int wram_banks = 8
) (
	input  logic                          clk_cpu,
	input  logic                          reset,
	input  logic [gb_map_pkg::addr_w-1:0] awaddr,
	input  logic                          awvalid,
	output logic                          awready,
	input  logic [gb_map_pkg::data_w-1:0] wdata,
	input  logic [gb_map_pkg::data_w/8-1:0] wstrb,
	input  logic                          wvalid,
	output logic                          wready,
	output logic [1:0]                    bresp,
	output logic                          bvalid,
	input  logic                          bready,
	input  logic [gb_map_pkg::addr_w-1:0] araddr,
	input  logic                          arvalid,
	output logic                          arready,
	output logic [gb_map_pkg::data_w-1:0] rdata,
	output logic [1:0]                    rresp,
	output logic                          rvalid,
	input  logic                          rready,
	input  logic [7:0]                    joystick,
	input  logic [1:0]                    ext_irq,  // vblank, lcdc
	input  logic                          irq_ack,
	output logic                          irq,
	output logic [7:0]                    irq_vector
);
	import gb_bus_pkg::*;

	// access side of the bus fsm
	logic [gb_map_pkg::addr_w-1:0] acc_addr;
	logic [gb_map_pkg::data_w-1:0] acc_wdata;
	logic                          acc_wr;
	logic                          acc_rd;
	logic [gb_map_pkg::data_w-1:0] rd_data;

	logic joy_we, timer_we, if_we, ie_we, svbk_we, wram_we, zp_we;
	logic [gb_map_pkg::data_w-1:0] joy_do, timer_do, if_do, ie_do;
	logic [gb_map_pkg::data_w-1:0] svbk_do, wram_do, zp_do;

	logic             timer_irq;
	logic             joy_irq;
	logic [irq_n-1:0] events;

	// --------------------
	// interrupt sources in priority order
	assign events[vblank] = ext_irq[0];
	assign events[lcdc]   = ext_irq[1];
	assign events[timer]  = timer_irq;
	assign events[serial] = 1'b0; // no link port
	assign events[joypad] = joy_irq;

	bus_fsm u_bus (
		.clk_cpu (clk_cpu), .reset (reset),
		.awaddr  (awaddr),  .awvalid (awvalid), .awready (awready),
		.wdata   (wdata),   .wstrb   (wstrb),   .wvalid  (wvalid), .wready (wready),
		.bresp   (bresp),   .bvalid  (bvalid),  .bready  (bready),
		.araddr  (araddr),  .arvalid (arvalid), .arready (arready),
		.rdata   (rdata),   .rresp   (rresp),   .rvalid  (rvalid), .rready (rready),
		.acc_addr (acc_addr), .acc_wdata (acc_wdata),
		.acc_wr   (acc_wr),   .acc_rd    (acc_rd),
		.rd_data  (rd_data)
	);

	io_decode u_decode (
		.clk_cpu (clk_cpu), .reset (reset),
		.acc_addr (acc_addr), .acc_wr (acc_wr), .acc_rd (acc_rd),
		.joy_we  (joy_we),  .timer_we (timer_we), .if_we (if_we), .ie_we (ie_we),
		.svbk_we (svbk_we), .wram_we  (wram_we),  .zp_we (zp_we),
		.joy_do  (joy_do),  .timer_do (timer_do), .if_do (if_do), .ie_do (ie_do),
		.svbk_do (svbk_do), .wram_do  (wram_do),  .zp_do (zp_do),
		.rd_data (rd_data)
	);

	gb_timer u_timer (
		.clk_cpu (clk_cpu), .reset (reset),
		.we      (timer_we),
		.addr    (acc_addr[1:0]),
		.wdata   (acc_wdata),
		.rdata   (timer_do),
		.timer_irq (timer_irq)
	);

	irq_ctrl u_irq (
		.clk_cpu (clk_cpu), .reset (reset),
		.if_we   (if_we),   .ie_we (ie_we),
		.wdata   (acc_wdata),
		.events  (events),
		.irq_ack (irq_ack),
		.if_do   (if_do),   .ie_do (ie_do),
		.irq     (irq),     .irq_vector (irq_vector)
	);

	joypad u_joypad (
		.clk_cpu (clk_cpu), .reset (reset),
		.we      (joy_we),
		.wdata   (acc_wdata),
		.joystick (joystick),
		.joy_do  (joy_do),
		.joy_irq (joy_irq)
	);

	work_ram #(.wram_banks (wram_banks)) u_ram (
		.clk_cpu (clk_cpu), .reset (reset),
		.wram_we (wram_we), .zp_we (zp_we), .svbk_we (svbk_we),
		.acc_addr  (acc_addr),
		.acc_wdata (acc_wdata),
		.wram_do (wram_do), .zp_do (zp_do), .svbk_do (svbk_do)
	);

endmodule

// File: test/tb_gb_io.sv
`timescale 1ns/1ps

module tb_gb_io;
	import gb_map_pkg::*;

	localparam int max_cycles = 20000; // ~600 bus accesses plus timer waits

	logic        clk_cpu = 1'b0;
	logic        reset;
	logic [15:0] awaddr, araddr;
	logic        awvalid, wvalid, bready, arvalid, rready;
	logic [7:0]  wdata;
	logic [0:0]  wstrb;
	logic        awready, wready, bvalid, arready, rvalid;
	logic [1:0]  bresp, rresp;
	logic [7:0]  rdata;
	logic [7:0]  joystick;
	logic [1:0]  ext_irq;
	logic        irq_ack;
	logic        irq;
	logic [7:0]  irq_vector;

	integer seed = 80155;
	int     cycles = 0;

	// model state
	logic [7:0]  m_wram [32768];
	logic [7:0]  m_zp [128];
	logic [2:0]  m_bank;
	logic [4:0]  m_if, m_ie;
	logic [1:0]  m_sel;      // joypad P15/P14
	logic [7:0]  m_d1, m_d2; // released = 1
	logic [15:0] m_cnt;
	logic [7:0]  m_tima, m_tma;
	logic [2:0]  m_tac;
	logic        m_tap_q;
	logic        m_wr = 1'b0, m_rd = 1'b0; // access strobe of the bus in flight
	logic [15:0] m_addr;
	logic [7:0]  m_data;
	logic [7:0]  exp_rd;

	gb_io_top #(.wram_banks(8)) dut (.*);

	always #5 clk_cpu = ~clk_cpu;

	task automatic report_error(input string msg);
		$display("[ERROR] %0t ns: %s", $time, msg);
		$display("Errors found");
		$fatal(1, "stopped at first failing check");
	endtask

	always @(posedge clk_cpu) begin
		cycles++;
		if (cycles >= max_cycles) begin
			$display("timeout: run did not finish within %0d clock cycles", max_cycles);
			$display("Errors found");
			$fatal(1, "simulation hung");
		end
	end

	function automatic int unsigned rand_below(input int unsigned n);
		return {$random(seed)} % n;
	endfunction

	// one-hot of the lowest numbered pending source
	function automatic logic [4:0] highest_priority(input logic [4:0] p);
		return p & (~p + 5'd1); // lowest set bit only
	endfunction

	function automatic logic [7:0] priority_vector(input logic [4:0] p);
		for (int i = 0; i < 5; i++)
			if (p[i]) return 8'h40 + 8'(8 * i);
		return 8'h55;
	endfunction

	function automatic logic [14:0] wram_index(input logic [15:0] a);
		return {a[12] ? m_bank : 3'd0, a[11:0]}; // c000-cfff is bank 0
	endfunction

	function automatic logic [7:0] model_read(input logic [15:0] a);
		logic [3:0] dir_n;
		logic [3:0] btn_n;
		logic [3:0] lines;
		dir_n = ~{joystick[2], joystick[3], joystick[1], joystick[0]}; // P13..P10
		btn_n = ~joystick[7:4];
		lines = 4'hf;
		if (!m_sel[0])
			lines = lines & dir_n; // P14 low enables directions
		if (!m_sel[1])
			lines = lines & btn_n;
		case (a)
			16'hff00: return {2'b11, m_sel, lines};
			16'hff04: return m_cnt[15:8];
			16'hff05: return m_tima;
			16'hff06: return m_tma;
			16'hff07: return {5'b11111, m_tac};
			16'hff0f: return {3'b111, m_if};
			16'hff70: return {5'b11111, m_bank};
			16'hffff: return {3'b000, m_ie};
			default: begin
				if (a >= 16'hc000 && a <= 16'hdfff) return m_wram[wram_index(a)];
				if (a >= 16'hff80) return m_zp[a[6:0]];
				return 8'hff; // unmapped
			end
		endcase
	endfunction

	// registers not touched by the cycle model below
	task automatic model_write(input logic [15:0] a, input logic [7:0] d);
		case (a)
			16'hff00: m_sel = d[5:4];
			16'hff06: m_tma = d;
			16'hff07: m_tac = d[2:0];
			16'hff70: m_bank = (d[2:0] == 3'd0) ? 3'd1 : d[2:0];
			16'hffff: m_ie = d[4:0];
			default: begin
				if (a >= 16'hc000 && a <= 16'hdfff) m_wram[wram_index(a)] = d;
				else if (a >= 16'hff80 && a != 16'hffff) m_zp[a[6:0]] = d;
			end
		endcase
	endtask

	// --------------------
	// cycle model reads old values before updating
	always @(posedge clk_cpu) begin : model
		logic       tap;
		logic       tick;
		logic       ovf;
		logic       wr_tima;
		logic [4:0] nxt;
		if (reset) begin
			m_bank  = 3'd1;
			m_if    = '0;
			m_ie    = '0;
			m_sel   = 2'b00;
			m_d1    = 8'hff;
			m_d2    = 8'hff;
			m_cnt   = '0;
			m_tima  = '0;
			m_tma   = '0;
			m_tac   = '0;
			m_tap_q = 1'b0;
		end else begin
			if (m_rd)
				exp_rd = model_read(m_addr); // value seen at handshake edge plus one
			case (m_tac[1:0])
				2'd0: tap = m_cnt[9];
				2'd1: tap = m_cnt[3];
				2'd2: tap = m_cnt[5];
				default: tap = m_cnt[7];
			endcase
			tap     = tap & m_tac[2];
			tick    = m_tap_q & ~tap;
			wr_tima = m_wr && m_addr == 16'hff05;
			ovf     = tick && m_tima == 8'hff && !wr_tima;
			nxt = (m_wr && m_addr == 16'hff0f) ? m_data[4:0] : m_if;
			if (irq_ack)
				nxt = nxt & ~highest_priority(m_if & m_ie);
			nxt  = nxt | {|(m_d2 & ~m_d1), 1'b0, ovf, ext_irq[1], ext_irq[0]};
			m_if = nxt;
			m_tap_q = tap;
			m_cnt   = (m_wr && m_addr == 16'hff04) ? 16'd0 : m_cnt + 16'd1;
			if (wr_tima)
				m_tima = m_data;
			else if (tick)
				m_tima = (m_tima == 8'hff) ? m_tma : m_tima + 8'd1; // reload
			if (m_wr)
				model_write(m_addr, m_data);
			m_d2 = m_d1;
			m_d1 = ~joystick;
		end
	end

	// irq output is combinational so it is checked every cycle
	always @(negedge clk_cpu) begin
		if (!reset) begin
			assert (irq === |(m_if & m_ie))
				else report_error($sformatf("irq %b, IE %h IF %h", irq, m_ie, m_if));
			assert (irq_vector === priority_vector(m_if & m_ie))
				else report_error($sformatf("irq_vector %h, expected %h", irq_vector,
					priority_vector(m_if & m_ie)));
		end
	end

	// --------------------
	// bus tasks
	task automatic axi_write(input logic [15:0] a, input logic [7:0] d);
		int delay;
		delay = rand_below(4);
		@(negedge clk_cpu);
		awaddr  = a;
		wdata   = d;
		wstrb   = 1'b1;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		while (!awready) @(negedge clk_cpu);
		assert (wready)
			else report_error($sformatf("write %h: awready high without wready", a));
		@(negedge clk_cpu); // handshake edge passed
		awvalid = 1'b0;
		wvalid  = 1'b0;
		m_addr  = a;
		m_data  = d;
		m_wr    = 1'b1;
		@(negedge clk_cpu);
		m_wr = 1'b0;
		repeat (delay) begin
			assert (bvalid && !arready && !awready && !wready)
				else report_error($sformatf("write %h: response dropped or ready high", a));
			@(negedge clk_cpu);
		end
		assert (bvalid && bresp == 2'b00)
			else report_error($sformatf("write %h: bvalid %b bresp %b", a, bvalid, bresp));
		bready = 1'b1;
		@(negedge clk_cpu);
		bready = 1'b0;
	endtask

	task automatic axi_read(input logic [15:0] a, output logic [7:0] d);
		int delay;
		delay = rand_below(4);
		@(negedge clk_cpu);
		araddr  = a;
		arvalid = 1'b1;
		while (!arready) @(negedge clk_cpu);
		@(negedge clk_cpu);
		arvalid = 1'b0;
		m_addr  = a;
		m_rd    = 1'b1;
		@(negedge clk_cpu);
		m_rd = 1'b0;
		@(negedge clk_cpu); // rvalid two edges after handshake
		repeat (delay) begin
			assert (rvalid && !arready && !awready && !wready)
				else report_error($sformatf("read %h: response dropped or ready high", a));
			@(negedge clk_cpu);
		end
		assert (rvalid && rresp == 2'b00)
			else report_error($sformatf("read %h: rvalid %b rresp %b", a, rvalid, rresp));
		assert (rdata === exp_rd)
			else report_error($sformatf("read %h: got %h, expected %h", a, rdata, exp_rd));
		d = rdata;
		rready = 1'b1;
		@(negedge clk_cpu);
		rready = 1'b0;
	endtask

	function automatic logic [15:0] ram_addr();
		case (rand_below(3))
			0: return 16'hc000 + 16'(rand_below(32));
			1: return 16'hd000 + 16'(rand_below(32));
			default: return 16'hff80 + 16'(rand_below(127));
		endcase
	endfunction

	task automatic pulse_events();
		@(negedge clk_cpu);
		ext_irq = 2'(rand_below(4));
		irq_ack = 1'(rand_below(2));
		@(negedge clk_cpu);
		ext_irq = 2'b00;
		irq_ack = 1'b0;
	endtask

	// --------------------
	initial begin
		logic [7:0] d;
		logic [7:0] old_js;
		int         tries;
		reset    = 1'b1;
		awaddr   = '0;
		awvalid  = 1'b0;
		wdata    = '0;
		wstrb    = '0;
		wvalid   = 1'b0;
		bready   = 1'b0;
		araddr   = '0;
		arvalid  = 1'b0;
		rready   = 1'b0;
		joystick = '0;
		ext_irq  = '0;
		irq_ack  = 1'b0;
		repeat (2) @(negedge clk_cpu);
		reset = 1'b0;

		// banked wram and zero page
		repeat (200) begin
			case (rand_below(10))
				0: axi_write(svbk_addr, 8'(rand_below(256)));
				1: axi_read(svbk_addr, d);
				2, 3, 4: axi_write(ram_addr(), 8'(rand_below(256)));
				default: axi_read(ram_addr(), d);
			endcase
		end

		// unmapped holes read ff
		axi_read(16'hff03, d);
		assert (d == 8'hff) else report_error($sformatf("ff03 read %h", d));
		axi_read(16'he000, d);
		axi_read(16'hfea0, d);

		// interrupt registers and priority
		repeat (80) begin
			case (rand_below(5))
				0: axi_write(ie_addr, 8'(rand_below(256)));
				1: axi_write(if_addr, 8'(rand_below(256)));
				2: pulse_events();
				3: axi_read(if_addr, d);
				default: axi_read(ie_addr, d);
			endcase
		end

		// timer registers
		repeat (80) begin
			case (rand_below(6))
				0: axi_write(tac_addr, 8'(rand_below(256)));
				1: axi_write(tma_addr, 8'(rand_below(256)));
				2: axi_write(div_addr, 8'(rand_below(256)));
				3: axi_read(div_addr, d);
				4: axi_read(tac_addr, d);
				default: axi_read(tima_addr, d);
			endcase
		end

		// overflow with a tick every 64 cycles
		axi_write(ie_addr, 8'h00);
		axi_write(if_addr, 8'h00);
		axi_write(tma_addr, 8'h5a);
		axi_write(tac_addr, 8'h06);
		axi_write(tima_addr, 8'hff);
		tries = 0;
		d = 8'h00;
		while (!d[2] && tries < 20) begin
			axi_read(if_addr, d);
			tries++;
		end
		assert (d[2]) else report_error("IF bit 2 not set after TIMA overflow");
		axi_read(tima_addr, d);
		assert (d == 8'h5a) else report_error($sformatf("TIMA after reload %h", d));

		// joypad press detection and select
		repeat (30) begin
			axi_write(if_addr, 8'h00);
			old_js = joystick;
			@(negedge clk_cpu);
			joystick = 8'(rand_below(256));
			axi_read(if_addr, d); // IF sampled under 3 cycles after the change
			if (|(joystick & ~old_js)) begin
				assert (d[4])
					else report_error("new press did not set IF bit 4 within 3 cycles");
			end
			axi_write(joy_addr, 8'(rand_below(4) << 4));
			axi_read(joy_addr, d);
		end

		$display("No errors");
		$finish;
	end

endmodule

// File: sim.f
common/gb_map_pkg.sv
common/gb_bus_pkg.sv
design/bus_fsm.sv
design/io_decode.sv
timer/gb_timer.sv
design/irq_ctrl.sv
design/joypad.sv
design/work_ram.sv
design/gb_io_top.sv
test/tb_gb_io.sv

// File: Bender.yml
package:
  name: gb_io

sources:
  - common/gb_map_pkg.sv
  - common/gb_bus_pkg.sv
  - design/bus_fsm.sv
  - design/io_decode.sv
  - timer/gb_timer.sv
  - design/irq_ctrl.sv
  - design/joypad.sv
  - design/work_ram.sv
  - design/gb_io_top.sv
  - target: test
    files:
      - test/tb_gb_io.sv
